//--- tb.f
+incdir+include
hw/mshr_pkg.sv
hw/mem_pkg.sv
hw/find_first_one.sv
hw/mshr_entry.sv
hw/mshr_file.sv
hw/mshr_ctrl_regs.sv
hw/dcache_miss_top.sv
dv/dcache_miss_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := dcache_miss_tb
FILELIST := tb.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	@grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/dcache_miss_tb.sv
`timescale 1ns/1ps
`include "mshr_consts.svh"

module dcache_miss_tb;

    import mshr_pkg::*;
    import mem_pkg::*;

    localparam int LIMIT_W  = `MSHR_ID_W + 1;
    localparam int PADDR_HI = `PADDR_W - 32;

    logic                  clock;
    logic                  arst_n;
    alloc_req_t            alloc0 = '0;
    alloc_req_t            alloc1 = '0;
    logic                  alloc0_grant;
    logic                  alloc1_grant;
    logic [`MSHR_ID_W-1:0] alloc0_id;
    logic [`MSHR_ID_W-1:0] alloc1_id;
    logic                  mem_req_valid;
    logic                  mem_req_ready = 1'b0;
    mem_req_t              mem_req;
    mem_resp_t             mem_resp = '0;
    refill_t               refill;
    cfg_wr_t               cfg;
    logic [15:0]           cfg_rdata;

    logic                  stim_en;
    logic                  after_reset;
    logic                  drained;
    logic [31:0]           lfsr_state = 32'he1c4_0049;
    logic [`LINE_W-1:0]    resp_line_rand;

    // shadow of every entry, indexed by mshrid
    logic [`MSHR_NUM-1:0]  busy;
    logic [`MSHR_NUM-1:0]  exp_store;
    logic [`PADDR_W-1:0]   exp_paddr [`MSHR_NUM];
    logic [`ROBID_W-1:0]   exp_robid [`MSHR_NUM];
    logic [`LINE_W-1:0]    exp_line [`MSHR_NUM];
    logic [`MSHR_NUM-1:0]  resp_wait;   // accepted by memory, answer not yet sent
    logic [2:0]            resp_delay [`MSHR_NUM];
    logic [`MSHR_NUM-1:0]  refill_pend; // line delivered, refill not yet seen
    logic [LIMIT_W-1:0]    shadow_limit;
    logic                  hold_armed;
    mem_req_t              held_req;

    logic [`MSHR_NUM-1:0]  allowed_free;
    logic [`MSHR_NUM-1:0]  answer_vec;
    logic [`MSHR_ID_W-1:0] answer_id;
    logic [`MSHR_ID_W-1:0] lowest_pend;
    logic [7:0]            free_cnt;
    logic [7:0]            busy_cnt;
    logic [1:0]            exp_grants;
    logic                  id0_busy;
    logic                  id1_busy;
    logic                  lower_alloc;
    logic [`PADDR_W-1:0]   req_exp_paddr;
    mem_op_e               req_exp_op;

    dcache_miss_top uut (
        .clock        (clock),
        .arst_n       (arst_n),
        .alloc0       (alloc0),
        .alloc1       (alloc1),
        .alloc0_grant (alloc0_grant),
        .alloc1_grant (alloc1_grant),
        .alloc0_id    (alloc0_id),
        .alloc1_id    (alloc1_id),
        .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp),
        .refill       (refill),
        .cfg          (cfg),
        .cfg_rdata    (cfg_rdata)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic logic [`LINE_W-1:0] random_line();
        logic [`LINE_W-1:0] l;
        l = '0;
        for (int w = 0; w < `LINE_W / 32; w++) begin
            l = {l[`LINE_W-33:0], take_bits(32)};
        end
        return l;
    endfunction

    function automatic alloc_req_t random_alloc(input logic enable);
        alloc_req_t a;
        a.valid    = enable && (take_bits(1) != 32'd0);
        a.paddr    = {PADDR_HI'(take_bits(PADDR_HI)), take_bits(32)};
        a.robid    = `ROBID_W'(take_bits(`ROBID_W));
        a.is_store = (take_bits(1) != 32'd0);
        return a;
    endfunction

    function automatic logic [`MSHR_ID_W-1:0] lowest_index(input logic [`MSHR_NUM-1:0] v);
        logic [`MSHR_ID_W-1:0] idx;
        idx = '0;
        for (int i = `MSHR_NUM - 1; i >= 0; i--) begin
            if (v[i]) begin
                idx = `MSHR_ID_W'(i);
            end
        end
        return idx;
    endfunction

    function automatic logic [7:0] count_ones(input logic [`MSHR_NUM-1:0] v);
        logic [7:0] n;
        n = '0;
        for (int i = 0; i < `MSHR_NUM; i++) begin
            n = n + 8'(v[i]);
        end
        return n;
    endfunction

    // a written limit lands between one and the entry count
    function automatic logic [LIMIT_W-1:0] expected_limit(input logic [LIMIT_W-1:0] k);
        if (k == '0) begin
            return LIMIT_W'(1);
        end else if (k > LIMIT_W'(`MSHR_NUM)) begin
            return LIMIT_W'(`MSHR_NUM);
        end
        return k;
    endfunction

    task automatic report_mismatch(input string name, input logic [`LINE_W-1:0] expected,
                                   input logic [`LINE_W-1:0] actual);
        $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("[ERROR] %s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clock);
    endtask

    task automatic write_limit(input logic [LIMIT_W-1:0] k);
        cfg <= '{we: 1'b1, limit: k};
        @(posedge clock);
        cfg <= '0;
    endtask

    task automatic wait_for_drain(input int limit, output logic done);
        int cycles;
        cycles = 0;
        while (busy != '0 && cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        done = (busy == '0);
    endtask

    always_comb begin
        for (int i = 0; i < `MSHR_NUM; i++) begin
            allowed_free[i] = !busy[i] && (LIMIT_W'(i) < shadow_limit);
            answer_vec[i]   = resp_wait[i] && (resp_delay[i] == 3'd0);
        end
    end

    assign free_cnt      = count_ones(allowed_free);
    assign busy_cnt      = count_ones(busy);
    assign answer_id     = lowest_index(answer_vec);
    assign lowest_pend   = lowest_index(refill_pend);
    assign exp_grants    = {alloc0.valid && free_cnt >= 8'd1, alloc1.valid && free_cnt >= 8'd2};
    assign id0_busy      = busy[alloc0_id];
    assign id1_busy      = busy[alloc1_id];
    assign req_exp_paddr = exp_paddr[mem_req.mshrid];
    assign req_exp_op    = exp_store[mem_req.mshrid] ? READ_UNIQUE : READ_SHARED;
    assign lower_alloc   = (alloc0_grant && alloc0_id < mem_req.mshrid) ||
                           (alloc1_grant && alloc1_id < mem_req.mshrid);

    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            alloc0        <= '0;
            alloc1        <= '0;
            mem_req_ready <= 1'b0;
            mem_resp      <= '0;
            busy          <= '0;
            resp_wait     <= '0;
            refill_pend   <= '0;
            shadow_limit  <= LIMIT_W'(`MSHR_NUM);
            hold_armed    <= 1'b0;
            held_req      <= '0;
        end else begin
            if (alloc0_grant) begin
                busy[alloc0_id]      <= 1'b1;
                exp_paddr[alloc0_id] <= alloc0.paddr;
                exp_robid[alloc0_id] <= alloc0.robid;
                exp_store[alloc0_id] <= alloc0.is_store;
            end
            if (alloc1_grant) begin
                busy[alloc1_id]      <= 1'b1;
                exp_paddr[alloc1_id] <= alloc1.paddr;
                exp_robid[alloc1_id] <= alloc1.robid;
                exp_store[alloc1_id] <= alloc1.is_store;
            end
            if (refill.valid) begin // entry is free again after this edge
                busy[refill.mshrid]        <= 1'b0;
                refill_pend[refill.mshrid] <= 1'b0;
            end
            if (mem_resp.valid) begin
                refill_pend[mem_resp.mshrid] <= 1'b1;
            end
            if (cfg.we) begin
                shadow_limit <= expected_limit(cfg.limit);
            end
            held_req   <= mem_req;
            hold_armed <= mem_req_valid && !mem_req_ready && !lower_alloc;

            // memory side answers each accepted read after a random delay
            for (int i = 0; i < `MSHR_NUM; i++) begin
                if (resp_wait[i] && resp_delay[i] != 3'd0) begin
                    resp_delay[i] <= resp_delay[i] - 3'd1;
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                resp_wait[mem_req.mshrid]  <= 1'b1;
                resp_delay[mem_req.mshrid] <= 3'(take_bits(3));
            end
            mem_resp <= '0;
            if (answer_vec != '0) begin
                resp_line_rand       = random_line();
                mem_resp             <= '{valid: 1'b1, mshrid: answer_id, line: resp_line_rand};
                exp_line[answer_id]  <= resp_line_rand;
                resp_wait[answer_id] <= 1'b0;
            end

            mem_req_ready <= (take_bits(1) != 32'd0);
            alloc0        <= random_alloc(stim_en);
            alloc1        <= random_alloc(stim_en);
        end
    end

    a_reset_state : assert property (@(posedge clock) disable iff (!arst_n)
        after_reset |-> {alloc0_grant, alloc1_grant, mem_req_valid, refill.valid, cfg_rdata}
                        == {4'b0000, 8'd0, 8'(`MSHR_NUM)})
        else report_mismatch("reset_state", `LINE_W'({4'b0000, 8'd0, 8'(`MSHR_NUM)}),
            `LINE_W'($sampled({alloc0_grant, alloc1_grant, mem_req_valid, refill.valid, cfg_rdata})));

    a_grant0_free : assert property (@(posedge clock) disable iff (!arst_n)
        alloc0_grant |-> !id0_busy)
        else report_mismatch("grant0_free", `LINE_W'(0), `LINE_W'($sampled(id0_busy)));

    a_grant1_free : assert property (@(posedge clock) disable iff (!arst_n)
        alloc1_grant |-> !id1_busy)
        else report_mismatch("grant1_free", `LINE_W'(0), `LINE_W'($sampled(id1_busy)));

    a_grant_ids_differ : assert property (@(posedge clock) disable iff (!arst_n)
        (alloc0_grant && alloc1_grant) |-> alloc0_id != alloc1_id)
        else report_failure("both allocation ports were granted the same entry");

    // a strobe is granted exactly when enough allowed entries are free
    a_grants_expected : assert property (@(posedge clock) disable iff (!arst_n)
        {alloc0_grant, alloc1_grant} == exp_grants)
        else report_mismatch("grants", `LINE_W'($sampled(exp_grants)),
            `LINE_W'($sampled({alloc0_grant, alloc1_grant})));

    a_grant_below_limit : assert property (@(posedge clock) disable iff (!arst_n)
        !((alloc0_grant && LIMIT_W'(alloc0_id) >= shadow_limit) ||
          (alloc1_grant && LIMIT_W'(alloc1_id) >= shadow_limit)))
        else report_failure("an entry at or above the entry limit was granted");

    a_req_paddr : assert property (@(posedge clock) disable iff (!arst_n)
        mem_req_valid |-> mem_req.paddr == req_exp_paddr)
        else report_mismatch("req_paddr", `LINE_W'($sampled(req_exp_paddr)),
            `LINE_W'($sampled(mem_req.paddr)));

    a_req_op : assert property (@(posedge clock) disable iff (!arst_n)
        mem_req_valid |-> mem_req.op == req_exp_op)
        else report_mismatch("req_op", `LINE_W'($sampled(req_exp_op)),
            `LINE_W'($sampled(mem_req.op)));

    a_req_hold : assert property (@(posedge clock) disable iff (!arst_n)
        hold_armed |-> mem_req_valid && mem_req == held_req)
        else report_mismatch("req_hold", `LINE_W'({1'b1, $sampled(held_req)}),
            `LINE_W'($sampled({mem_req_valid, mem_req})));

    a_refill_tag : assert property (@(posedge clock) disable iff (!arst_n)
        refill.valid |-> {refill.paddr, refill.robid}
                         == {exp_paddr[refill.mshrid], exp_robid[refill.mshrid]})
        else report_mismatch("refill_tag",
            `LINE_W'($sampled({exp_paddr[refill.mshrid], exp_robid[refill.mshrid]})),
            `LINE_W'($sampled({refill.paddr, refill.robid})));

    a_refill_line : assert property (@(posedge clock) disable iff (!arst_n)
        refill.valid |-> refill.line == exp_line[refill.mshrid])
        else report_mismatch("refill_line", $sampled(exp_line[refill.mshrid]),
            $sampled(refill.line));

    a_refill_order : assert property (@(posedge clock) disable iff (!arst_n)
        (refill.valid || refill_pend != '0) |->
        {refill.valid, refill.mshrid} == {refill_pend != '0, lowest_pend})
        else report_mismatch("refill_order", `LINE_W'($sampled({refill_pend != '0, lowest_pend})),
            `LINE_W'($sampled({refill.valid, refill.mshrid})));

    a_cfg_readback : assert property (@(posedge clock) disable iff (!arst_n)
        cfg_rdata == {busy_cnt, 8'(shadow_limit)})
        else report_mismatch("cfg_readback", `LINE_W'($sampled({busy_cnt, 8'(shadow_limit)})),
            `LINE_W'($sampled(cfg_rdata)));

    initial begin
        arst_n      = 1'b0;
        cfg         = '0;
        stim_en     = 1'b0;
        after_reset = 1'b0;
        repeat (2) @(posedge clock);
        arst_n      <= 1'b1;
        after_reset <= 1'b1;
        @(posedge clock);
        after_reset <= 1'b0;
        stim_en     <= 1'b1;
        run_cycles(300);
        write_limit(LIMIT_W'(3)); // entries above the new limit drain on their own
        run_cycles(200);
        write_limit(LIMIT_W'(0));
        run_cycles(150);
        write_limit(LIMIT_W'(15));
        run_cycles(200);
        stim_en <= 1'b0;
        run_cycles(3);
        wait_for_drain(1000, drained);
        if (!drained) begin
            $display("[ERROR] entries were still busy long after traffic stopped");
            $display("ERRORS FOUND");
            $fatal(1);
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- hw/dcache_miss_top.sv
`timescale 1ns/1ps
`include "mshr_consts.svh"

module dcache_miss_top (
    input  logic                  clock,
    input  logic                  arst_n,
    input  mshr_pkg::alloc_req_t  alloc0,
    input  mshr_pkg::alloc_req_t  alloc1,
    output logic                  alloc0_grant,
    output logic                  alloc1_grant,
    output logic [`MSHR_ID_W-1:0] alloc0_id,
    output logic [`MSHR_ID_W-1:0] alloc1_id,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output mem_pkg::mem_req_t     mem_req,
    input  mem_pkg::mem_resp_t    mem_resp,
    output mshr_pkg::refill_t     refill,
    input  mshr_pkg::cfg_wr_t     cfg,
    output logic [15:0]           cfg_rdata
);

    logic [`MSHR_NUM-1:0] alloc_mask; // from the limit register
    logic [`MSHR_NUM-1:0] valid_vec;  // busy entries, counted for readback

    mshr_file u_mshr_file (
        .clock        (clock),
        .arst_n       (arst_n),
        .alloc0       (alloc0),
        .alloc1       (alloc1),
        .alloc_mask   (alloc_mask),
        .alloc0_grant (alloc0_grant),
        .alloc1_grant (alloc1_grant),
        .alloc0_id    (alloc0_id),
        .alloc1_id    (alloc1_id),
        .valid_vec    (valid_vec),
        .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp),
        .refill       (refill)
    );

    mshr_ctrl_regs u_ctrl_regs (
        .clock     (clock),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .valid_vec (valid_vec),
        .alloc_mask(alloc_mask),
        .cfg_rdata (cfg_rdata)
    );

endmodule

//--- hw/mshr_ctrl_regs.sv
`timescale 1ns/1ps
`include "mshr_consts.svh"

module mshr_ctrl_regs (
    input  logic                 clock,
    input  logic                 arst_n,
    input  mshr_pkg::cfg_wr_t    cfg,
    input  logic [`MSHR_NUM-1:0] valid_vec,
    output logic [`MSHR_NUM-1:0] alloc_mask,
    output logic [15:0]          cfg_rdata
);

    localparam int LIMIT_W = `MSHR_ID_W + 1;
    localparam logic [LIMIT_W-1:0] LIMIT_MAX = LIMIT_W'(`MSHR_NUM);

    logic [LIMIT_W-1:0] entry_limit;
    logic [LIMIT_W-1:0] limit_clamped;
    logic [LIMIT_W-1:0] occupancy;

    // a zero limit would lock out every miss, so it becomes one
    always_comb begin
        if (cfg.limit == '0) begin
            limit_clamped = LIMIT_W'(1);
        end else if (cfg.limit > LIMIT_MAX) begin
            limit_clamped = LIMIT_MAX;
        end else begin
            limit_clamped = cfg.limit;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            entry_limit <= LIMIT_MAX;
        end else if (cfg.we) begin
            entry_limit <= limit_clamped;
        end
    end

    // the mask only gates new allocations, busy entries finish as usual
    always_comb begin
        for (int i = 0; i < `MSHR_NUM; i++) begin
            alloc_mask[i] = (LIMIT_W'(i) < entry_limit);
        end
    end

    always_comb begin
        occupancy = '0;
        for (int i = 0; i < `MSHR_NUM; i++) begin
            occupancy = occupancy + LIMIT_W'(valid_vec[i]);
        end
    end

    assign cfg_rdata = {8'(occupancy), 8'(entry_limit)}; // occupancy high, limit low

    a_limit_in_range : assert property (
        @(posedge clock) disable iff (!arst_n)
        entry_limit <= LIMIT_MAX && entry_limit != '0
    );

endmodule

//--- hw/mshr_file.sv
`timescale 1ns/1ps
`include "mshr_consts.svh"

module mshr_file (
    input  logic                  clock,
    input  logic                  arst_n,
    input  mshr_pkg::alloc_req_t  alloc0,
    input  mshr_pkg::alloc_req_t  alloc1,
    input  logic [`MSHR_NUM-1:0]  alloc_mask,
    output logic                  alloc0_grant,
    output logic                  alloc1_grant,
    output logic [`MSHR_ID_W-1:0] alloc0_id,
    output logic [`MSHR_ID_W-1:0] alloc1_id,
    output logic [`MSHR_NUM-1:0]  valid_vec,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output mem_pkg::mem_req_t     mem_req,
    input  mem_pkg::mem_resp_t    mem_resp,
    output mshr_pkg::refill_t     refill
);

    import mshr_pkg::*;
    import mem_pkg::*;

    entry_state_e state_vec [`MSHR_NUM];
    mem_req_t     req_vec [`MSHR_NUM];
    refill_t      refill_vec [`MSHR_NUM];
    alloc_req_t   install_vec [`MSHR_NUM];

    logic [`MSHR_NUM-1:0] free_vec;
    logic [`MSHR_NUM-1:0] free_except_ff0;
    logic [`MSHR_NUM-1:0] ff0_oh;
    logic [`MSHR_NUM-1:0] ff1_oh;
    logic                 ff0_valid;
    logic                 ff1_valid;

    logic [`MSHR_NUM-1:0] issue_vec;
    logic [`MSHR_NUM-1:0] issue_oh;
    logic [`MSHR_NUM-1:0] issue_grant_vec;
    logic [`MSHR_NUM-1:0] refill_rdy_vec;
    logic [`MSHR_NUM-1:0] refill_oh;
    logic                 refill_any;
    logic [`MSHR_NUM-1:0] resp_hit_vec;

    function automatic logic [`MSHR_ID_W-1:0] onehot_to_id(input logic [`MSHR_NUM-1:0] oh);
        logic [`MSHR_ID_W-1:0] id;
        id = '0;
        for (int i = 0; i < `MSHR_NUM; i++) begin
            if (oh[i]) begin
                id = id | `MSHR_ID_W'(i);
            end
        end
        return id;
    endfunction

    always_comb begin
        for (int i = 0; i < `MSHR_NUM; i++) begin
            valid_vec[i]      = (state_vec[i] != IDLE);
            issue_vec[i]      = (state_vec[i] == ISSUE);
            refill_rdy_vec[i] = (state_vec[i] == REFILL);
            resp_hit_vec[i]   = mem_resp.valid && (mem_resp.mshrid == `MSHR_ID_W'(i));
        end
    end

    assign free_vec        = ~valid_vec & alloc_mask; // entries above the limit are never offered
    assign free_except_ff0 = free_vec & ~ff0_oh;

    find_first_one #(.WIDTH(`MSHR_NUM)) u_ff0 (
        .in_vector(free_vec),
        .onehot   (ff0_oh),
        .valid    (ff0_valid)
    );

    find_first_one #(.WIDTH(`MSHR_NUM)) u_ff1 (
        .in_vector(free_except_ff0),
        .onehot   (ff1_oh),
        .valid    (ff1_valid)
    );

    assign alloc0_grant = alloc0.valid && ff0_valid;
    assign alloc1_grant = alloc1.valid && ff1_valid;
    assign alloc0_id    = onehot_to_id(ff0_oh);
    assign alloc1_id    = onehot_to_id(ff1_oh);

    always_comb begin
        for (int i = 0; i < `MSHR_NUM; i++) begin
            if (ff0_oh[i] && alloc0.valid) begin
                install_vec[i] = alloc0;
            end else if (ff1_oh[i] && alloc1.valid) begin
                install_vec[i] = alloc1;
            end else begin
                install_vec[i] = '0;
            end
        end
    end

    // the pick only moves when an entry leaves ISSUE or a lower one enters it
    find_first_one #(.WIDTH(`MSHR_NUM)) u_issue_pick (
        .in_vector(issue_vec),
        .onehot   (issue_oh),
        .valid    (mem_req_valid)
    );

    assign issue_grant_vec = issue_oh & {`MSHR_NUM{mem_req_ready}};

    always_comb begin
        mem_req = '0;
        for (int i = 0; i < `MSHR_NUM; i++) begin
            if (issue_oh[i]) begin
                mem_req = req_vec[i];
            end
        end
    end

    find_first_one #(.WIDTH(`MSHR_NUM)) u_refill_pick (
        .in_vector(refill_rdy_vec),
        .onehot   (refill_oh),
        .valid    (refill_any)
    );

    always_comb begin
        refill = '0; // valid stays low when nobody is refilling
        for (int i = 0; i < `MSHR_NUM; i++) begin
            if (refill_oh[i] && refill_any) begin
                refill = refill_vec[i];
            end
        end
    end

    genvar g;
    generate
        for (g = 0; g < `MSHR_NUM; g++) begin : g_entry
            mshr_entry #(
                .ENTRY_ID(g)
            ) u_entry (
                .clock       (clock),
                .arst_n      (arst_n),
                .install     (install_vec[g]),
                .issue_grant (issue_grant_vec[g]),
                .resp_hit    (resp_hit_vec[g]),
                .resp_line   (mem_resp.line),
                .refill_grant(refill_oh[g]),
                .state       (state_vec[g]),
                .issue_req   (req_vec[g]),
                .refill      (refill_vec[g])
            );
        end
    endgenerate

    a_grants_onehot : assert property (
        @(posedge clock) disable iff (!arst_n)
        $onehot0(issue_grant_vec) && $onehot0(refill_oh)
    );

    a_alloc_distinct : assert property (
        @(posedge clock) disable iff (!arst_n)
        (alloc0_grant && alloc1_grant) |-> (alloc0_id != alloc1_id)
    );

    // a response may only return to an entry still waiting for its line
    a_resp_to_waiting : assert property (
        @(posedge clock) disable iff (!arst_n)
        mem_resp.valid |-> state_vec[mem_resp.mshrid] == WAIT_RESP
    );

endmodule

//--- hw/mshr_entry.sv
`timescale 1ns/1ps
`include "mshr_consts.svh"

module mshr_entry #(
    parameter int ENTRY_ID = 0
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  mshr_pkg::alloc_req_t  install,
    input  logic                  issue_grant,
    input  logic                  resp_hit,
    input  logic [`LINE_W-1:0]    resp_line,
    input  logic                  refill_grant,
    output mshr_pkg::entry_state_e state,
    output mem_pkg::mem_req_t     issue_req,
    output mshr_pkg::refill_t     refill
);

    import mshr_pkg::*;
    import mem_pkg::*;

    localparam logic [`MSHR_ID_W-1:0] MY_ID = `MSHR_ID_W'(ENTRY_ID);

    logic [`PADDR_W-1:0] paddr;
    logic [`ROBID_W-1:0] robid;
    mem_op_e             op;
    logic [`LINE_W-1:0]  line;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (install.valid) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (issue_grant) begin // request taken by the next level
                        state <= WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if (resp_hit) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (refill_grant) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // miss details are captured once when the entry is claimed
    always_ff @(posedge clock) begin
        if (install.valid && state == IDLE) begin
            paddr <= install.paddr;
            robid <= install.robid;
            op    <= install.is_store ? READ_UNIQUE : READ_SHARED;
        end
        if (resp_hit && state == WAIT_RESP) begin
            line <= resp_line;
        end
    end

    always_comb begin
        issue_req.paddr  = paddr;
        issue_req.mshrid = MY_ID;
        issue_req.op     = op;
    end

    always_comb begin
        refill.valid  = (state == REFILL);
        refill.paddr  = paddr;
        refill.robid  = robid;
        refill.mshrid = MY_ID;
        refill.line   = line;
    end

    // the allocator must only hand out entries that are free
    a_install_when_idle : assert property (
        @(posedge clock) disable iff (!arst_n)
        install.valid |-> state == IDLE
    );

endmodule

//--- hw/find_first_one.sv
`timescale 1ns/1ps

module find_first_one #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] in_vector,
    output logic [WIDTH-1:0] onehot,
    output logic             valid
);

    logic [WIDTH-1:0] negated;

    // two's complement keeps the lowest set bit and clears every bit below it
    assign negated = ~in_vector + WIDTH'(1);

    // anding with the input drops the bits above the lowest set one
    assign onehot  = in_vector & negated;

    assign valid   = |in_vector; // nothing to pick on an all-zero input

endmodule

//--- hw/mem_pkg.sv
`include "mshr_consts.svh"

package mem_pkg;

    // loads ask for a shared copy, stores for an exclusive one
    typedef enum logic {
        READ_SHARED,
        READ_UNIQUE
    } mem_op_e;

    typedef struct packed {
        logic [`PADDR_W-1:0]   paddr;
        logic [`MSHR_ID_W-1:0] mshrid;
        mem_op_e               op;
    } mem_req_t;

    typedef struct packed {
        logic                  valid;
        logic [`MSHR_ID_W-1:0] mshrid; // entry that asked for this line
        logic [`LINE_W-1:0]    line;
    } mem_resp_t;

endpackage

//--- hw/mshr_pkg.sv
`include "mshr_consts.svh"

package mshr_pkg;

    // life of one miss entry
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_RESP,
        REFILL
    } entry_state_e;

    typedef struct packed {
        logic                  valid;
        logic [`PADDR_W-1:0]   paddr;
        logic [`ROBID_W-1:0]   robid;
        logic                  is_store; // selects a unique read
    } alloc_req_t;

    typedef struct packed {
        logic                  valid;
        logic [`PADDR_W-1:0]   paddr;
        logic [`ROBID_W-1:0]   robid;
        logic [`MSHR_ID_W-1:0] mshrid;
        logic [`LINE_W-1:0]    line;
    } refill_t;

    // the limit has one more bit than an id so it can hold MSHR_NUM itself
    typedef struct packed {
        logic                  we;
        logic [`MSHR_ID_W:0]   limit;
    } cfg_wr_t;

endpackage

//--- include/mshr_consts.svh
`ifndef MSHR_CONSTS_SVH
`define MSHR_CONSTS_SVH

// number of miss entries held by the file
`define MSHR_NUM 8

// bits needed to name one entry
`define MSHR_ID_W 3

`define PADDR_W 40 // physical line address

// ROB id with its wrap bit on top
`define ROBID_W 7

// a full cache line as returned by the next level, 16 words
`define LINE_W 512

`endif
